// File: sim.f
source/ex_pkg.sv
source/ex_stage_if.sv
source/ex_decoder.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_stage.sv
source/ex_result_stage.sv
source/ex_top.sv
tb/tb_clk_gen.sv
tb/tb_ex_top.sv

// File: source/ex_alu.sv
// Single-cycle integer ALU
// Add/sub, logic, shifts, signed and unsigned compares,
// plus signed overflow detect on add and subtract
module ex_alu
  import ex_pkg::*;
(
  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            overflow_o
);

  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] diff;
  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;
  logic            add_ovf;
  logic            sub_ovf;

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Only the low 5 bits of b count as shift amount
  assign shamt = operand_b_i[4:0];

  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  ////////////////////////////////////////
  // Signed overflow
  ////////////////////////////////////////
  // Add overflows when both signs match and the sum sign differs
  assign add_ovf = (operand_a_i[XLEN-1] == operand_b_i[XLEN-1]) &
                   (sum[XLEN-1] != operand_a_i[XLEN-1]);
  // Sub overflows when signs differ and the result takes b's sign
  assign sub_ovf = (operand_a_i[XLEN-1] != operand_b_i[XLEN-1]) &
                   (diff[XLEN-1] != operand_a_i[XLEN-1]);

  always_comb begin
    case (operator_i)
      ALU_ADD:  overflow_o = add_ovf;
      ALU_SUB:  overflow_o = sub_ovf;
      default:  overflow_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////
  always_comb begin
    case (operator_i)
      ALU_ADD:  result_o = sum;
      ALU_SUB:  result_o = diff;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Compares return 0 or 1
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      default:  result_o = '0;
    endcase
  end

endmodule

// File: source/ex_decoder.sv
// Decode stage
// Registers one issued instruction and maps its operation field
// onto ALU or multiplier opcodes for the execute stage
module ex_decoder
  import ex_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,

  // Issue port
  input  logic               issue_valid_i,
  output logic               issue_ready_o,
  input  op_field_e          issue_op_i,
  input  logic [RADDR_W-1:0] issue_rd_i,
  input  logic [XLEN-1:0]    issue_a_i,
  input  logic [XLEN-1:0]    issue_b_i,

  // Decoded request toward execute
  ex_req_if.dec              req
);

  // Combinational decode of the incoming field
  logic    dec_is_mul;
  alu_op_e dec_alu_op;
  mul_op_e dec_mul_op;
  logic    dec_clr_ov;
  logic    dec_illegal;

  // Pipeline register
  logic               valid_q;
  logic               is_mul_q;
  alu_op_e            alu_op_q;
  mul_op_e            mul_op_q;
  logic               clr_ov_q;
  logic               illegal_q;
  logic [RADDR_W-1:0] rd_q;
  logic [XLEN-1:0]    op_a_q;
  logic [XLEN-1:0]    op_b_q;

  logic issue_xfer;

  always_comb begin
    dec_is_mul  = 1'b0;
    dec_alu_op  = ALU_NOP;
    dec_mul_op  = MUL_LO;
    dec_clr_ov  = 1'b0;
    dec_illegal = 1'b0;
    case (issue_op_i)
      OP_ADD:   dec_alu_op = ALU_ADD;
      OP_SUB:   dec_alu_op = ALU_SUB;
      OP_AND:   dec_alu_op = ALU_AND;
      OP_OR:    dec_alu_op = ALU_OR;
      OP_XOR:   dec_alu_op = ALU_XOR;
      OP_SLL:   dec_alu_op = ALU_SLL;
      OP_SRL:   dec_alu_op = ALU_SRL;
      OP_SRA:   dec_alu_op = ALU_SRA;
      OP_SLT:   dec_alu_op = ALU_SLT;
      OP_SLTU:  dec_alu_op = ALU_SLTU;
      OP_MUL: begin
        dec_is_mul = 1'b1;
        dec_mul_op = MUL_LO;
      end
      OP_MULH: begin
        dec_is_mul = 1'b1;
        dec_mul_op = MUL_HSS;
      end
      OP_MULHU: begin
        dec_is_mul = 1'b1;
        dec_mul_op = MUL_HUU;
      end
      // Flag clear rides the ALU path as a NOP
      OP_CLROV: dec_clr_ov = 1'b1;
      // Unassigned codes pass on as a NOP marked illegal
      default:  dec_illegal = 1'b1;
    endcase
  end

  // Free when empty or when the held item leaves this cycle
  assign issue_ready_o = ~valid_q | req.ready;
  assign issue_xfer    = issue_valid_i & issue_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (issue_ready_o) begin
      valid_q <= issue_valid_i;
    end
  end

  // Payload loads only on an accepted issue
  always_ff @(posedge clk) begin
    if (issue_xfer) begin
      is_mul_q  <= dec_is_mul;
      alu_op_q  <= dec_alu_op;
      mul_op_q  <= dec_mul_op;
      clr_ov_q  <= dec_clr_ov;
      illegal_q <= dec_illegal;
      rd_q      <= issue_rd_i;
      op_a_q    <= issue_a_i;
      op_b_q    <= issue_b_i;
    end
  end

  assign req.valid   = valid_q;
  assign req.is_mul  = is_mul_q;
  assign req.alu_op  = alu_op_q;
  assign req.mul_op  = mul_op_q;
  assign req.clr_ov  = clr_ov_q;
  assign req.illegal = illegal_q;
  assign req.rd      = rd_q;
  assign req.op_a    = op_a_q;
  assign req.op_b    = op_b_q;

endmodule

// File: source/ex_mult.sv
// Iterative shift-add multiplier
// Retires MUL_BITS_PER_CYCLE multiplier bits per cycle into a
// double-width accumulator, then returns the low or high word
module ex_mult
  import ex_pkg::*;
#(
  parameter int unsigned MUL_BITS_PER_CYCLE = 4
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  mul_op_e         operator_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  output logic            busy_o,
  output logic            done_o,
  output logic [XLEN-1:0] result_o
);

  localparam int unsigned STEPS = XLEN / MUL_BITS_PER_CYCLE;
  localparam int unsigned CNT_W = $clog2(STEPS);

  // Control
  logic             busy_q;
  logic             done_q;
  logic [CNT_W-1:0] cnt_q;
  logic             last_step;

  // Datapath
  logic [2*XLEN-1:0]             mcand_q;
  logic [XLEN-1:0]               mplier_q;
  logic [2*XLEN-1:0]             acc_q;
  logic [2*XLEN-1:0]             partial;
  logic [MUL_BITS_PER_CYCLE-1:0] chunk;
  logic                          b_signed_q;
  mul_op_e                       op_q;
  logic                          a_signed;

  assign last_step = (cnt_q == CNT_W'(STEPS - 1));
  assign chunk     = mplier_q[MUL_BITS_PER_CYCLE-1:0];
  // Only the signed high word needs signed operands
  assign a_signed  = (operator_i == MUL_HSS);

  // Partial product of this step's multiplier chunk
  always_comb begin
    partial = '0;
    for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
      if (chunk[i]) begin
        partial = partial + (mcand_q << i);
      end
    end
    // Top bit of a signed multiplier has negative weight
    if (last_step && b_signed_q && chunk[MUL_BITS_PER_CYCLE-1]) begin
      partial = partial - (mcand_q << MUL_BITS_PER_CYCLE);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      // One-cycle done pulse after the final step
      done_q <= busy_q & last_step;
      if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (last_step) begin
          busy_q <= 1'b0;
        end
      end else if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end
    end
  end

  // Multiplicand sign- or zero-extended to accumulator width
  always_ff @(posedge clk) begin
    if (!busy_q && start_i) begin
      mcand_q    <= {{XLEN{a_signed & op_a_i[XLEN-1]}}, op_a_i};
      mplier_q   <= op_b_i;
      acc_q      <= '0;
      b_signed_q <= a_signed;
      op_q       <= operator_i;
    end else if (busy_q) begin
      acc_q    <= acc_q + partial;
      mcand_q  <= mcand_q << MUL_BITS_PER_CYCLE;
      mplier_q <= mplier_q >> MUL_BITS_PER_CYCLE;
    end
  end

  assign busy_o   = busy_q;
  assign done_o   = done_q;
  // Accumulator holds still until the next start
  assign result_o = (op_q == MUL_LO) ? acc_q[XLEN-1:0] : acc_q[2*XLEN-1:XLEN];

endmodule

// File: source/ex_pkg.sv
// Execute subsystem package
// Data widths, issue operation-field encoding and unit opcodes
package ex_pkg;

  // Data path and register address widths
  localparam int unsigned XLEN    = 32;
  localparam int unsigned RADDR_W = 5;

  ////////////////////////////////////////
  // Issue operation field
  ////////////////////////////////////////
  // Codes 14 and 15 are not assigned and decode as illegal
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLL   = 4'd5,
    OP_SRL   = 4'd6,
    OP_SRA   = 4'd7,
    OP_SLT   = 4'd8,
    OP_SLTU  = 4'd9,
    OP_MUL   = 4'd10,
    OP_MULH  = 4'd11,
    OP_MULHU = 4'd12,
    OP_CLROV = 4'd13
  } op_field_e;

  ////////////////////////////////////////
  // Unit opcodes
  ////////////////////////////////////////
  // ALU functions, NOP gives a zero result
  typedef enum logic [3:0] {
    ALU_NOP,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // Multiplier: low word, signed high word, unsigned high word
  typedef enum logic [1:0] {
    MUL_LO,
    MUL_HSS,
    MUL_HUU
  } mul_op_e;

endpackage

// File: source/ex_result_stage.sv
// Write-back register stage
// One-entry buffer toward the register file with valid/ready
module ex_result_stage
  import ex_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  ex_res_if.res              res,

  // Write-back port
  output logic               wb_valid_o,
  input  logic               wb_ready_i,
  output logic [RADDR_W-1:0] wb_rd_o,
  output logic               wb_we_o,
  output logic [XLEN-1:0]    wb_data_o,
  output logic               wb_illegal_o
);

  logic               valid_q;
  logic               we_q;
  logic [RADDR_W-1:0] rd_q;
  logic [XLEN-1:0]    data_q;
  logic               illegal_q;
  logic               res_xfer;

  // Accept when empty or when the current entry drains
  assign res.ready = ~valid_q | wb_ready_i;
  assign res_xfer  = res.valid & res.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
    end else if (res.ready) begin
      valid_q <= res.valid;
      if (res_xfer) begin
        we_q <= res.we;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (res_xfer) begin
      rd_q      <= res.rd;
      data_q    <= res.data;
      illegal_q <= res.illegal;
    end
  end

  assign wb_valid_o   = valid_q;
  assign wb_rd_o      = rd_q;
  assign wb_we_o      = we_q;
  assign wb_data_o    = data_q;
  assign wb_illegal_o = illegal_q;

endmodule

// File: source/ex_stage.sv
// Execute stage
// Steers decoded items to the single-cycle ALU or the iterative
// multiplier and keeps the sticky signed-overflow flag
module ex_stage
  import ex_pkg::*;
#(
  parameter int unsigned MUL_BITS_PER_CYCLE = 4
) (
  input  logic clk,
  input  logic rst_n,
  ex_req_if.ex req,
  ex_res_if.ex res,
  output logic ovf_o,
  output logic mul_busy_o
);

  typedef enum logic [1:0] {
    EX_IDLE,
    EX_MUL,
    EX_MUL_DONE
  } ex_state_e;

  ex_state_e state_q;
  ex_state_e state_d;

  logic [XLEN-1:0]    alu_result;
  logic               alu_ovf;
  logic               alu_xfer;
  logic               mul_start;
  logic               mul_busy;
  logic               mul_done;
  logic [XLEN-1:0]    mul_result;
  logic [RADDR_W-1:0] mul_rd_q;
  logic               ovf_q;

  ////////////////////////////////////////
  // Units
  ////////////////////////////////////////
  ex_alu i_alu (
    .operator_i  (req.alu_op),
    .operand_a_i (req.op_a),
    .operand_b_i (req.op_b),
    .result_o    (alu_result),
    .overflow_o  (alu_ovf)
  );

  ex_mult #(
    .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
  ) i_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (mul_start),
    .operator_i (req.mul_op),
    .op_a_i     (req.op_a),
    .op_b_i     (req.op_b),
    .busy_o     (mul_busy),
    .done_o     (mul_done),
    .result_o   (mul_result)
  );

  ////////////////////////////////////////
  // Steering FSM
  ////////////////////////////////////////
  always_comb begin
    state_d     = state_q;
    req.ready   = 1'b0;
    mul_start   = 1'b0;
    res.valid   = 1'b0;
    res.rd      = req.rd;
    // Illegal and flag-clear items write nothing back
    res.we      = ~req.illegal & ~req.clr_ov;
    res.illegal = req.illegal;
    res.data    = alu_result;
    case (state_q)
      EX_IDLE: begin
        if (req.valid) begin
          if (req.is_mul) begin
            // Take the operands and block the link until done
            req.ready = 1'b1;
            mul_start = 1'b1;
            state_d   = EX_MUL;
          end else begin
            // ALU path passes straight through
            res.valid = 1'b1;
            req.ready = res.ready;
          end
        end
      end
      EX_MUL, EX_MUL_DONE: begin
        res.rd      = mul_rd_q;
        res.we      = 1'b1;
        res.illegal = 1'b0;
        res.data    = mul_result;
        if (mul_done || state_q == EX_MUL_DONE) begin
          res.valid = 1'b1;
          // Park here while write-back stalls
          state_d   = res.ready ? EX_IDLE : EX_MUL_DONE;
        end
      end
      default: state_d = EX_IDLE;
    endcase
  end

  // ALU item leaving the stage this cycle
  assign alu_xfer = (state_q == EX_IDLE) & req.valid & ~req.is_mul & res.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= EX_IDLE;
      ovf_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Sticky flag, cleared only by CLROV
      if (alu_xfer) begin
        if (req.clr_ov) begin
          ovf_q <= 1'b0;
        end else if (alu_ovf) begin
          ovf_q <= 1'b1;
        end
      end
    end
  end

  // Destination of the multiply in flight
  always_ff @(posedge clk) begin
    if (mul_start) begin
      mul_rd_q <= req.rd;
    end
  end

  assign ovf_o      = ovf_q;
  assign mul_busy_o = mul_busy;

endmodule

// File: source/ex_stage_if.sv
// Execute subsystem stage-to-stage links
// Decoded request (decoder to execute) and result (execute to write-back)

interface ex_req_if
  import ex_pkg::*;
();
  logic               valid;
  logic               ready;
  logic               is_mul;
  alu_op_e            alu_op;
  mul_op_e            mul_op;
  logic               clr_ov;
  logic               illegal;
  logic [RADDR_W-1:0] rd;
  logic [XLEN-1:0]    op_a;
  logic [XLEN-1:0]    op_b;

  modport dec (output valid, is_mul, alu_op, mul_op, clr_ov, illegal, rd, op_a, op_b,
               input  ready);
  modport ex  (input  valid, is_mul, alu_op, mul_op, clr_ov, illegal, rd, op_a, op_b,
               output ready);
endinterface

interface ex_res_if
  import ex_pkg::*;
();
  logic               valid;
  logic               ready;
  logic [RADDR_W-1:0] rd;
  logic               we;
  logic [XLEN-1:0]    data;
  logic               illegal;

  modport ex  (output valid, rd, we, data, illegal, input  ready);
  modport res (input  valid, rd, we, data, illegal, output ready);
endinterface

// File: source/ex_top.sv
// Integer execute subsystem top level
// Decode, execute and write-back stages in a valid/ready pipeline
module ex_top
  import ex_pkg::*;
#(
  parameter int unsigned MUL_BITS_PER_CYCLE = 4
) (
  input  logic               clk,
  input  logic               rst_n,

  // Issue port
  input  logic               issue_valid_i,
  output logic               issue_ready_o,
  input  op_field_e          issue_op_i,
  input  logic [RADDR_W-1:0] issue_rd_i,
  input  logic [XLEN-1:0]    issue_a_i,
  input  logic [XLEN-1:0]    issue_b_i,

  // Write-back port
  output logic               wb_valid_o,
  input  logic               wb_ready_i,
  output logic [RADDR_W-1:0] wb_rd_o,
  output logic               wb_we_o,
  output logic [XLEN-1:0]    wb_data_o,
  output logic               wb_illegal_o,

  // Status
  output logic               ovf_o,
  output logic               mul_busy_o
);

  ex_req_if req_if ();
  ex_res_if res_if ();

  ex_decoder i_decoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_op_i    (issue_op_i),
    .issue_rd_i    (issue_rd_i),
    .issue_a_i     (issue_a_i),
    .issue_b_i     (issue_b_i),
    .req           (req_if.dec)
  );

  ex_stage #(
    .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
  ) i_ex_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req_if.ex),
    .res        (res_if.ex),
    .ovf_o      (ovf_o),
    .mul_busy_o (mul_busy_o)
  );

  ex_result_stage i_result_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .res          (res_if.res),
    .wb_valid_o   (wb_valid_o),
    .wb_ready_i   (wb_ready_i),
    .wb_rd_o      (wb_rd_o),
    .wb_we_o      (wb_we_o),
    .wb_data_o    (wb_data_o),
    .wb_illegal_o (wb_illegal_o)
  );

endmodule

// File: tb/tb_clk_gen.sv
// Testbench clock and reset source
// Clock period 4, reset held low over the first three rising edges
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release lands just after an edge, in step with the stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

// File: tb/tb_ex_top.sv
// Testbench for the integer execute subsystem
// Directed and random issue traffic against a reference model,
// with random write-back back-pressure and a cycle watchdog
module tb_ex_top
  import ex_pkg::*;
();

  localparam int MUL_BPC        = 4;
  localparam int STEPS          = 32 / MUL_BPC;
  localparam int N_RANDOM       = 400;
  // Latency probes, flag sequence, multiply corners and random traffic
  localparam int N_INSTR        = 2 + 12 + 48 + N_RANDOM;
  localparam int TIMEOUT_CYCLES = N_INSTR * (32 / MUL_BPC + 4) * 2 + 100;

  // Expected write-back item
  typedef struct packed {
    logic [RADDR_W-1:0] rd;
    logic               we;
    logic [XLEN-1:0]    data;
    logic               illegal;
    logic               ovf;
    logic               is_mul;
  } exp_item_t;

  logic               clk;
  logic               rst_n;
  logic               issue_valid_i;
  logic               issue_ready_o;
  op_field_e          issue_op_i;
  logic [RADDR_W-1:0] issue_rd_i;
  logic [XLEN-1:0]    issue_a_i;
  logic [XLEN-1:0]    issue_b_i;
  logic               wb_valid_o;
  logic               wb_ready_i;
  logic [RADDR_W-1:0] wb_rd_o;
  logic               wb_we_o;
  logic [XLEN-1:0]    wb_data_o;
  logic               wb_illegal_o;
  logic               ovf_o;
  logic               mul_busy_o;

  exp_item_t exp_q[$];
  logic [31:0] seed;
  logic        ref_ovf;
  logic        bp_on;
  int          mismatch_count;
  int          fail_count;
  int          checked_count;
  int          busy_cycles;
  int          mul_results;
  int          cycle_count;

  // Last write-back outputs seen by the stall check
  logic               stalled;
  logic [RADDR_W-1:0] held_rd;
  logic               held_we;
  logic [XLEN-1:0]    held_data;
  logic               held_illegal;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_top #(
    .MUL_BITS_PER_CYCLE (MUL_BPC)
  ) i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_op_i    (issue_op_i),
    .issue_rd_i    (issue_rd_i),
    .issue_a_i     (issue_a_i),
    .issue_b_i     (issue_b_i),
    .wb_valid_o    (wb_valid_o),
    .wb_ready_i    (wb_ready_i),
    .wb_rd_o       (wb_rd_o),
    .wb_we_o       (wb_we_o),
    .wb_data_o     (wb_data_o),
    .wb_illegal_o  (wb_illegal_o),
    .ovf_o         (ovf_o),
    .mul_busy_o    (mul_busy_o)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic [31:0] rand_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] corner_value(input logic [1:0] idx);
    case (idx)
      2'd0:    return 32'h0000_0000;
      2'd1:    return 32'hffff_ffff;
      2'd2:    return 32'h8000_0000;
      default: return 32'h7fff_ffff;
    endcase
  endfunction

  // One operand in four comes from the corner table
  function automatic logic [31:0] random_operand();
    logic [31:0] sel;
    sel = rand_next();
    if (sel[31:30] == 2'b00) begin
      return corner_value(sel[17:16]);
    end
    return rand_next();
  endfunction

  // Expected result of one instruction from the flag before it
  function automatic exp_item_t ref_exec(input logic [3:0] code, input logic [31:0] a,
                                         input logic [31:0] b, input logic ovf_prev);
    exp_item_t   r;
    logic [32:0] wide;
    logic [63:0] prod_s;
    logic [63:0] prod_u;
    r        = '0;
    r.we     = 1'b1;
    r.ovf    = ovf_prev;
    prod_u   = {32'b0, a} * {32'b0, b};
    prod_s   = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    case (code)
      4'd0: begin
        // Overflow when the 33-bit sum leaves the 32-bit signed range
        wide   = $signed({a[31], a}) + $signed({b[31], b});
        r.data = wide[31:0];
        if (wide[32] != wide[31]) r.ovf = 1'b1;
      end
      4'd1: begin
        wide   = $signed({a[31], a}) - $signed({b[31], b});
        r.data = wide[31:0];
        if (wide[32] != wide[31]) r.ovf = 1'b1;
      end
      4'd2:  r.data = a & b;
      4'd3:  r.data = a | b;
      4'd4:  r.data = a ^ b;
      4'd5:  r.data = a << b[4:0];
      4'd6:  r.data = a >> b[4:0];
      4'd7:  r.data = $signed(a) >>> b[4:0];
      4'd8:  r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4'd9:  r.data = (a < b) ? 32'd1 : 32'd0;
      4'd10: r.data = prod_u[31:0];
      4'd11: r.data = prod_s[63:32];
      4'd12: r.data = prod_u[63:32];
      4'd13: begin
        r.we  = 1'b0;
        r.ovf = 1'b0;
      end
      default: begin
        r.we      = 1'b0;
        r.illegal = 1'b1;
      end
    endcase
    r.is_mul = (code >= 4'd10) && (code <= 4'd12);
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH t=%0t %s: got %h, expected %h", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  // Step to just after the next rising edge and redraw back-pressure
  task automatic next_cycle();
    @(posedge clk);
    #1;
    wb_ready_i = bp_on ? (((rand_next() >> 16) % 100) >= 40) : 1'b1;
  endtask

  // Hold one instruction on the issue port until it is taken
  task automatic issue(input logic [3:0] code, input logic [4:0] rd,
                       input logic [31:0] a, input logic [31:0] b);
    exp_item_t item;
    logic      taken;
    issue_valid_i = 1'b1;
    issue_op_i    = op_field_e'(code);
    issue_rd_i    = rd;
    issue_a_i     = a;
    issue_b_i     = b;
    taken         = 1'b0;
    while (!taken) begin
      @(negedge clk);
      if (issue_ready_o) begin
        taken   = 1'b1;
        item    = ref_exec(code, a, b, ref_ovf);
        item.rd = rd;
        ref_ovf = item.ovf;
        exp_q.push_back(item);
      end
      next_cycle();
    end
    issue_valid_i = 1'b0;
  endtask

  // ALU op into an idle pipeline and count edges until write-back
  task automatic latency_check(input logic [3:0] code, input logic [31:0] a,
                               input logic [31:0] b);
    int edges;
    while (exp_q.size() != 0 || wb_valid_o) begin
      next_cycle();
    end
    issue(code, 5'd9, a, b);
    edges = 1;
    @(negedge clk);
    while (!wb_valid_o && edges < 10) begin
      next_cycle();
      edges++;
      @(negedge clk);
    end
    check_value("wb_valid_o latency in edges", edges, 2);
    // Hand back just after a rising edge like every other stimulus step
    next_cycle();
  endtask

  task automatic finish_run();
    $display("Results checked: %0d, mismatches: %0d, other errors: %0d",
             checked_count, mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////
  // Sampled mid-cycle where every output and input is settled
  always @(negedge clk) begin
    exp_item_t exp_item;
    if (rst_n) begin
      if (mul_busy_o) begin
        busy_cycles++;
      end
      // A stalled result must not move
      if (stalled) begin
        check_value("wb_valid_o (stalled)", wb_valid_o, 1);
        check_value("wb_rd_o (stalled)", wb_rd_o, held_rd);
        check_value("wb_we_o (stalled)", wb_we_o, held_we);
        check_value("wb_data_o (stalled)", wb_data_o, held_data);
        check_value("wb_illegal_o (stalled)", wb_illegal_o, held_illegal);
      end
      stalled      = wb_valid_o & ~wb_ready_i;
      held_rd      = wb_rd_o;
      held_we      = wb_we_o;
      held_data    = wb_data_o;
      held_illegal = wb_illegal_o;
      if (wb_valid_o && wb_ready_i) begin
        assert (exp_q.size() > 0) else begin
          $display("ERROR t=%0t: write-back result with no instruction outstanding", $time);
          fail_count++;
        end
        if (exp_q.size() > 0) begin
          exp_item = exp_q.pop_front();
          checked_count++;
          check_value("wb_rd_o", wb_rd_o, exp_item.rd);
          check_value("wb_we_o", wb_we_o, exp_item.we);
          check_value("wb_illegal_o", wb_illegal_o, exp_item.illegal);
          check_value("ovf_o", ovf_o, exp_item.ovf);
          if (exp_item.we) begin
            check_value("wb_data_o", wb_data_o, exp_item.data);
          end
          // Each multiply keeps the unit busy for STEPS cycles first
          if (exp_item.is_mul) begin
            mul_results++;
            assert (busy_cycles >= mul_results * STEPS &&
                    busy_cycles <= (mul_results + 1) * STEPS) else begin
              $display("ERROR t=%0t: multiplier busy for %0d cycles over %0d multiplies",
                       $time, busy_cycles, mul_results);
              fail_count++;
            end
          end
        end
      end
    end
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("ERROR: run did not complete in %0d cycles, %0d results outstanding",
             TIMEOUT_CYCLES, exp_q.size());
    fail_count++;
    finish_run();
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    logic [3:0]  code;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    seed           = 32'h566ea9bc;
    ref_ovf        = 1'b0;
    bp_on          = 1'b0;
    stalled        = 1'b0;
    mismatch_count = 0;
    fail_count     = 0;
    checked_count  = 0;
    busy_cycles    = 0;
    mul_results    = 0;
    issue_valid_i  = 1'b0;
    issue_op_i     = OP_ADD;
    issue_rd_i     = '0;
    issue_a_i      = '0;
    issue_b_i      = '0;
    wb_ready_i     = 1'b1;

    // Reset values sampled while reset is still low
    #1;
    @(negedge clk);
    check_value("wb_valid_o in reset", wb_valid_o, 0);
    check_value("wb_we_o in reset", wb_we_o, 0);
    check_value("mul_busy_o in reset", mul_busy_o, 0);
    check_value("ovf_o in reset", ovf_o, 0);
    check_value("issue_ready_o in reset", issue_ready_o, 1);
    @(posedge rst_n);

    latency_check(4'd0, 32'd5, 32'd7);
    latency_check(4'd9, 32'hffff_fffe, 32'd3);

    // Sticky flag across set, hold, illegal and clear
    issue(4'd0, 5'd1, 32'h7fff_ffff, 32'd1);
    issue(4'd2, 5'd2, 32'hffff_0000, 32'h1234_5678);
    issue(4'd14, 5'd3, 32'd1, 32'd2);
    issue(4'd8, 5'd4, 32'h8000_0000, 32'd1);
    issue(4'd15, 5'd5, 32'd3, 32'd4);
    issue(4'd13, 5'd6, 32'd0, 32'd0);
    issue(4'd1, 5'd7, 32'h8000_0000, 32'd1);
    issue(4'd13, 5'd8, 32'd0, 32'd0);
    issue(4'd0, 5'd10, 32'h8000_0000, 32'h8000_0000);
    issue(4'd0, 5'd11, 32'd1, 32'd1);
    issue(4'd1, 5'd12, 32'd0, 32'h8000_0000);
    issue(4'd13, 5'd13, 32'd0, 32'd0);

    // Every multiply flavour over all corner pairs
    for (int k = 0; k < 3; k++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          issue(4'(10 + k), 5'(i * 4 + j), corner_value(2'(i)), corner_value(2'(j)));
        end
      end
    end

    // Random traffic with issue gaps and back-pressure
    bp_on = 1'b1;
    repeat (N_RANDOM) begin
      while ((rand_next() >> 30) == 0) begin
        next_cycle();
      end
      code = 4'(rand_next() >> 16);
      rd   = 5'(rand_next() >> 20);
      a    = random_operand();
      b    = random_operand();
      issue(code, rd, a, b);
    end

    // Drain and then look for stray results
    for (int i = 0; i < 400 && exp_q.size() != 0; i++) begin
      next_cycle();
    end
    bp_on = 1'b0;
    repeat (10) begin
      next_cycle();
    end
    assert (exp_q.size() == 0) else begin
      $display("ERROR: %0d issued instructions never produced a result", exp_q.size());
      fail_count++;
    end
    finish_run();
  end

endmodule
